//--- Makefile
# Verilator build and run for the eth_trans testbench

VERILATOR ?= verilator
TOP       ?= eth_trans_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Verification passed" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/eth_trans_patterns.mem
// one frame per line: corrupt flag, corrupt byte index (0..29), then 16 payload bytes
// flipped byte index counts from the first preamble byte; index below 7 keeps the frame good
00 00 00 01 02 03 04 05 06 07 08 09 0A 0B 0C 0D 0E 0F
00 00 A5 5A 3C C3 F0 0F 81 18 7E E7 12 34 56 78 9A BC
01 0C DE AD BE EF 01 23 45 67 89 AB CD EF FE DC BA 98
00 00 11 22 33 44 55 66 77 88 99 AA BB CC DD EE FF 00
01 1C 5A 5A 5A 5A D5 D5 55 55 00 FF 00 FF 80 01 40 02
01 03 C0 FF EE 15 60 0D F0 0D 13 57 9B DF 24 68 AC E0
01 09 70 71 72 73 74 75 76 77 78 79 7A 7B 7C 7D 7E 7F
00 00 FF FE FD FC FB FA F9 F8 F7 F6 F5 F4 F3 F2 F1 F0

//--- dv/eth_trans_tb.sv
// eth_trans testbench loops GMII out to GMII in, replays pattern frames and checks bytes and words
`timescale 1ns/1ps

module eth_trans_tb
    import eth_trans_pkg::*;
();

    localparam int CLK_PERIOD     = 100;
    localparam int NUM_REC        = 8;
    localparam int REC_BYTES      = PAYLOAD_LEN + 2;             // flag, index, payload
    localparam int FRAME_BYTES    = PREAMBLE_LEN + 1 + 2 + PAYLOAD_LEN + 4;
    localparam int TIMEOUT_CYCLES = NUM_REC * 200 + 8 + 16;
    localparam logic [31:0] FCS_POLY = 32'hEDB8_8320;

    logic        sys_clk;
    logic        rst;
    logic        data_tx_vsync;
    logic        data_tx_href;
    logic [7:0]  source_tx_data;
    logic        data_rx_rd_en;
    logic [15:0] rx_data;
    logic        data_rx_ready;
    gmii_t       gmii_tx;
    gmii_t       gmii_rx;

    logic [7:0]  pat_mem [NUM_REC * REC_BYTES];
    logic [15:0] exp_q [$];                                      // words still owed by the sink
    logic        cur_corrupt;
    int          cur_idx;
    int          tx_idx;                                         // byte position in current frame
    int          seed;

    eth_trans i_eth_trans (
        .sys_clk        (sys_clk),
        .rst            (rst),
        .data_tx_vsync  (data_tx_vsync),
        .data_tx_href   (data_tx_href),
        .source_tx_data (source_tx_data),
        .data_rx_rd_en  (data_rx_rd_en),
        .rx_data        (rx_data),
        .data_rx_ready  (data_rx_ready),
        .gmii_tx        (gmii_tx),
        .gmii_rx        (gmii_rx)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    always_ff @(posedge sys_clk) begin
        tx_idx <= gmii_tx.en ? tx_idx + 1 : 0;
    end

    // link loopback that can flip bit 0 of one byte
    always_comb begin
        gmii_rx = gmii_tx;
        if (cur_corrupt && gmii_tx.en && tx_idx == cur_idx) begin
            gmii_rx.d = gmii_tx.d ^ 8'h01;
        end
    end

    // reflected crc-32 with the data byte folded in before the shifts
    function automatic logic [31:0] crc_update_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] r;
        r = crc ^ {24'h0, b};
        repeat (8) r = r[0] ? ((r >> 1) ^ FCS_POLY) : (r >> 1);
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic write_byte(input logic [7:0] b);
        int gap;
        data_tx_href   = 1'b1;
        source_tx_data = b;
        @(negedge sys_clk);
        data_tx_href = 1'b0;
        gap = $unsigned($random(seed)) % 3;                      // 0 to 2 idle cycles
        repeat (gap) @(negedge sys_clk);
    endtask

    task automatic pulse_vsync();
        data_tx_vsync = 1'b1;
        @(negedge sys_clk);
        data_tx_vsync = 1'b0;
        @(negedge sys_clk);
    endtask

    task automatic run_record(input int r);
        logic [7:0]  pay [PAYLOAD_LEN];
        logic [7:0]  exp_frame [FRAME_BYTES];
        logic [7:0]  frame [FRAME_BYTES];
        logic [31:0] crc;
        logic        bad;
        int          base;
        base        = r * REC_BYTES;
        cur_corrupt = pat_mem[base][0];
        cur_idx     = int'(pat_mem[base + 1]);
        for (int i = 0; i < PAYLOAD_LEN; i++) pay[i] = pat_mem[base + 2 + i];

        // preamble damage still leaves a good frame
        bad = cur_corrupt && (cur_idx >= PREAMBLE_LEN);
        if (!bad) begin
            for (int i = 0; i < PAYLOAD_LEN; i += 2) exp_q.push_back({pay[i], pay[i + 1]});
        end

        for (int i = 0; i < PREAMBLE_LEN; i++) exp_frame[i] = 8'h55;
        exp_frame[7] = 8'hD5;
        exp_frame[8] = 8'(PAYLOAD_LEN >> 8);                     // length field goes high byte first
        exp_frame[9] = 8'(PAYLOAD_LEN);
        crc = 32'hFFFF_FFFF;
        crc = crc_update_byte(crc, exp_frame[8]);
        crc = crc_update_byte(crc, exp_frame[9]);
        for (int i = 0; i < PAYLOAD_LEN; i++) begin
            exp_frame[10 + i] = pay[i];
            crc = crc_update_byte(crc, pay[i]);
        end
        crc = ~crc;
        for (int k = 0; k < 4; k++) exp_frame[26 + k] = crc[8 * k +: 8];

        if (r % 2 == 1) begin
            repeat (5) write_byte(8'($random(seed)));           // partial line that vsync drops
        end
        pulse_vsync();
        for (int i = 0; i < PAYLOAD_LEN; i++) write_byte(pay[i]);

        while (!gmii_tx.en) @(negedge sys_clk);
        for (int i = 0; i < FRAME_BYTES; i++) begin
            check_value("gmii_tx.en", 32'(gmii_tx.en), 32'd1);
            frame[i] = gmii_tx.d;
            @(negedge sys_clk);
        end
        check_value("gmii_tx.en after frame", 32'(gmii_tx.en), 32'd0);
        for (int i = 0; i < FRAME_BYTES; i++) begin
            check_value($sformatf("gmii_tx.d byte %0d", i), 32'(frame[i]), 32'(exp_frame[i]));
        end

        if (bad) begin
            repeat (IFG_LEN) begin
                check_value("data_rx_ready", 32'(data_rx_ready), 32'd0);
                @(negedge sys_clk);
            end
        end else begin
            while (exp_q.size() > 0) begin
                while (!data_rx_ready) @(negedge sys_clk);
                check_value("rx_data", 32'(rx_data), 32'(exp_q.pop_front()));
                data_rx_rd_en = 1'b1;
                @(negedge sys_clk);
                data_rx_rd_en = 1'b0;
            end
            check_value("data_rx_ready after reads", 32'(data_rx_ready), 32'd0);
        end
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed           = 32'h6cbb;
        rst            = 1'b1;
        data_tx_vsync  = 1'b0;
        data_tx_href   = 1'b0;
        source_tx_data = 8'h00;
        data_rx_rd_en  = 1'b0;
        cur_corrupt    = 1'b0;
        cur_idx        = 0;
        $readmemh("dv/eth_trans_patterns.mem", pat_mem);
        if ($isunknown(pat_mem[NUM_REC * REC_BYTES - 1])) begin
            $display("The pattern file dv/eth_trans_patterns.mem is missing or too short");
            $display("Verification failed");
            $fatal(1, "no stimulus");
        end

        repeat (8) @(negedge sys_clk);
        rst = 1'b0;
        @(negedge sys_clk);
        check_value("data_rx_ready after reset", 32'(data_rx_ready), 32'd0);
        check_value("gmii_tx.en after reset", 32'(gmii_tx.en), 32'd0);

        for (int r = 0; r < NUM_REC; r++) run_record(r);

        $display("Verification passed");
        $finish;
    end

endmodule

//--- logic/byte_fifo.sv
// byte_fifo: synchronous byte FIFO with flush and fill count, feeds the MAC transmitter
`timescale 1ns/1ps

module byte_fifo
    import eth_trans_pkg::*;
(
    input  logic       sys_clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic [6:0] count,
    output logic       full,
    output logic       empty
);

    logic [7:0]          mem [TX_FIFO_DEPTH];
    logic [TX_FIFO_AW:0] wr_ptr;                   // extra msb tells full from empty
    logic [TX_FIFO_AW:0] rd_ptr;
    logic                do_wr;
    logic                do_rd;

    assign count = wr_ptr - rd_ptr;
    assign full  = (count == 7'(TX_FIFO_DEPTH));
    assign empty = (count == 7'd0);

    assign do_wr = wr_en && !full;                 // overflow bytes are lost
    assign do_rd = rd_en && !empty;

    always_ff @(posedge sys_clk) begin
        if (do_wr) begin
            mem[wr_ptr[TX_FIFO_AW-1:0]] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr[TX_FIFO_AW-1:0]]; // valid one cycle after rd_en
        end
    end

    always_ff @(posedge sys_clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // the transmitter only reads once a whole payload is buffered
    a_no_read_empty: assert property (@(posedge sys_clk) disable iff (rst)
        rd_en |-> !empty);

    // source rate must stay below the link drain rate
    a_no_write_full: assert property (@(posedge sys_clk) disable iff (rst)
        wr_en |-> !full);

endmodule

//--- logic/eth_trans.sv
// eth_trans: source framing into the tx FIFO, MAC transmit and receive, and the rx word cache
`timescale 1ns/1ps

module eth_trans
    import eth_trans_pkg::*;
(
    input  logic        sys_clk,
    input  logic        rst,
    input  logic        data_tx_vsync,
    input  logic        data_tx_href,
    input  logic [7:0]  source_tx_data,
    input  logic        data_rx_rd_en,
    output logic [15:0] rx_data,
    output logic        data_rx_ready,
    output gmii_t       gmii_tx,
    input  gmii_t       gmii_rx
);

    logic          href_q;
    logic          vsync_q;
    logic          vsync_qq;                       // previous vsync for edge detect
    logic [7:0]    data_q;
    logic          fifo_flush;
    logic          fifo_rd_en;
    logic [7:0]    fifo_data;
    logic [6:0]    fifo_count;
    rec_byte_t     rec;
    frame_status_t status;

    always_ff @(posedge sys_clk) begin
        data_q <= source_tx_data;
        if (rst) begin
            href_q   <= 1'b0;
            vsync_q  <= 1'b0;
            vsync_qq <= 1'b0;
        end else begin
            href_q   <= data_tx_href;
            vsync_q  <= data_tx_vsync;
            vsync_qq <= vsync_q;
        end
    end

    assign fifo_flush = vsync_q && !vsync_qq;      // new frame drops any partial line

    byte_fifo u_tx_fifo (
        .sys_clk (sys_clk),
        .rst     (rst),
        .flush   (fifo_flush),
        .wr_en   (href_q),
        .wr_data (data_q),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_data),
        .count   (fifo_count),
        .full    (),
        .empty   ()
    );

    mac_tx u_mac_tx (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .fifo_count (fifo_count),
        .fifo_data  (fifo_data),
        .fifo_rd_en (fifo_rd_en),
        .gmii_tx    (gmii_tx)
    );

    mac_rx u_mac_rx (
        .sys_clk (sys_clk),
        .rst     (rst),
        .gmii_rx (gmii_rx),
        .rec     (rec),
        .status  (status)
    );

    rx_cache u_rx_cache (
        .sys_clk (sys_clk),
        .rst     (rst),
        .rec     (rec),
        .status  (status),
        .rd_en   (data_rx_rd_en),
        .rd_data (rx_data),
        .ready   (data_rx_ready)
    );

endmodule

//--- logic/eth_trans_pkg.sv
// eth_trans shared constants, link structs and the CRC-32 byte update used by both MACs
package eth_trans_pkg;

    localparam int PAYLOAD_LEN    = 16;        // payload bytes per frame, keep even
    localparam int PREAMBLE_LEN   = 7;
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE      = 8'hD5;
    localparam int IFG_LEN        = 12;        // idle cycles after a frame

    localparam int TX_FIFO_DEPTH  = 64;
    localparam int TX_FIFO_AW     = $clog2(TX_FIFO_DEPTH);
    localparam int RX_CACHE_WORDS = 32;
    localparam int RX_CACHE_AW    = $clog2(RX_CACHE_WORDS);

    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;   // ieee poly, reflected

    // one gmii byte lane
    typedef struct packed {
        logic [7:0] d;
        logic       en;
    } gmii_t;

    // payload byte handed from mac_rx to the cache
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } rec_byte_t;

    // end of frame verdict, done is a single-cycle pulse
    typedef struct packed {
        logic done;
        logic good;
    } frame_status_t;

    // reflected crc-32, one byte per call, lsb first
    function automatic logic [31:0] crc32_next(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            c = (c[0] ^ data[i]) ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

//--- logic/mac_rx.sv
// mac_rx: finds the SFD on GMII, forwards payload bytes and checks length and FCS
`timescale 1ns/1ps

module mac_rx
    import eth_trans_pkg::*;
(
    input  logic          sys_clk,
    input  logic          rst,
    input  gmii_t         gmii_rx,
    output rec_byte_t     rec,
    output frame_status_t status
);

    typedef enum logic [1:0] {
        S_HUNT,
        S_LEN,
        S_PAY,
        S_FCS
    } rx_state_t;

    rx_state_t   state;
    logic [4:0]  cnt;
    logic [31:0] crc;
    logic [31:0] crc_inv;
    logic [7:0]  len_hi;
    logic        fcs_ok;                           // all fcs bytes so far matched
    logic        armed;                            // en seen low since last frame
    logic        fcs_match;

    assign crc_inv   = ~crc;
    assign fcs_match = (gmii_rx.d == crc_inv[{cnt[1:0], 3'b000} +: 8]);

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state  <= S_HUNT;
            cnt    <= '0;
            armed  <= 1'b0;
            rec    <= '0;
            status <= '0;
        end else begin
            rec.valid   <= 1'b0;
            status.done <= 1'b0;
            status.good <= 1'b0;
            if (!gmii_rx.en) armed <= 1'b1;

            if (state != S_HUNT && !gmii_rx.en) begin
                status.done <= 1'b1;               // en dropped early, bad frame
                state       <= S_HUNT;
            end else begin
                case (state)
                    S_HUNT: begin
                        // payload bytes never restart a frame, only a fresh en does
                        if (gmii_rx.en && armed && gmii_rx.d == SFD_BYTE) begin
                            armed <= 1'b0;
                            cnt   <= '0;
                            crc   <= CRC_INIT;
                            state <= S_LEN;
                        end
                    end
                    S_LEN: begin
                        crc <= crc32_next(crc, gmii_rx.d);
                        cnt <= cnt + 1'b1;
                        if (cnt == 5'd0) begin
                            len_hi <= gmii_rx.d;
                        end else if ({len_hi, gmii_rx.d} == 16'(PAYLOAD_LEN)) begin
                            cnt   <= '0;
                            state <= S_PAY;
                        end else begin
                            status.done <= 1'b1;   // unexpected length
                            state       <= S_HUNT;
                        end
                    end
                    S_PAY: begin
                        crc      <= crc32_next(crc, gmii_rx.d);
                        rec.data <= gmii_rx.d;
                        rec.valid <= 1'b1;
                        cnt      <= cnt + 1'b1;
                        if (cnt == 5'(PAYLOAD_LEN - 1)) begin
                            cnt   <= '0;
                            state <= S_FCS;
                        end
                    end
                    S_FCS: begin
                        cnt    <= cnt + 1'b1;
                        fcs_ok <= (cnt == 5'd0) ? fcs_match : (fcs_ok && fcs_match);
                        if (cnt == 5'd3) begin
                            status.done <= 1'b1;
                            status.good <= fcs_ok && fcs_match;
                            state       <= S_HUNT;
                        end
                    end
                    default: state <= S_HUNT;
                endcase
            end
        end
    end

endmodule

//--- logic/mac_tx.sv
// mac_tx builds preamble, SFD, length, payload and FCS from the transmit FIFO onto GMII
`timescale 1ns/1ps

module mac_tx
    import eth_trans_pkg::*;
(
    input  logic       sys_clk,
    input  logic       rst,
    input  logic [6:0] fifo_count,
    input  logic [7:0] fifo_data,
    output logic       fifo_rd_en,
    output gmii_t      gmii_tx
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_PRE,
        S_SFD,
        S_LEN,
        S_PAY,
        S_FCS,
        S_GAP
    } tx_state_t;

    tx_state_t   state;
    logic [4:0]  cnt;                              // byte index inside the current field
    logic [31:0] crc;
    logic [31:0] fcs;
    logic [7:0]  tx_byte;

    assign fcs       = ~crc;

    always_comb begin
        case (state)
            S_PRE:   tx_byte = PREAMBLE_BYTE;
            S_SFD:   tx_byte = SFD_BYTE;
            S_LEN:   tx_byte = cnt[0] ? 8'(PAYLOAD_LEN) : 8'(PAYLOAD_LEN >> 8); // high byte first
            S_PAY:   tx_byte = fifo_data;
            S_FCS:   tx_byte = fcs[{cnt[1:0], 3'b000} +: 8]; // lsb byte first
            default: tx_byte = 8'h00;
        endcase
    end

    assign gmii_tx.d  = tx_byte;
    assign gmii_tx.en = (state != S_IDLE) && (state != S_GAP);

    // one read ahead so each payload byte lands as its cycle starts
    assign fifo_rd_en = ((state == S_LEN) && (cnt == 5'd1)) ||
                        ((state == S_PAY) && (cnt != 5'(PAYLOAD_LEN - 1)));

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            state <= S_IDLE;
            cnt   <= '0;
            crc   <= CRC_INIT;
        end else begin
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    crc <= CRC_INIT;
                    if (fifo_count >= 7'(PAYLOAD_LEN)) state <= S_PRE;
                end
                S_PRE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 5'(PREAMBLE_LEN - 1)) begin
                        cnt   <= '0;
                        state <= S_SFD;
                    end
                end
                S_SFD: begin
                    state <= S_LEN;
                end
                S_LEN: begin
                    crc <= crc32_next(crc, tx_byte);
                    cnt <= cnt + 1'b1;
                    if (cnt == 5'd1) begin
                        cnt   <= '0;
                        state <= S_PAY;
                    end
                end
                S_PAY: begin
                    crc <= crc32_next(crc, tx_byte);
                    cnt <= cnt + 1'b1;
                    if (cnt == 5'(PAYLOAD_LEN - 1)) begin
                        cnt   <= '0;
                        state <= S_FCS;
                    end
                end
                S_FCS: begin                       // crc held while its bytes go out
                    cnt <= cnt + 1'b1;
                    if (cnt == 5'd3) begin
                        cnt   <= '0;
                        state <= S_GAP;
                    end
                end
                S_GAP: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == 5'(IFG_LEN - 1)) state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // the receiver relies on en staying up through a whole frame
    a_en_holds: assert property (@(posedge sys_clk) disable iff (rst)
        (gmii_tx.en && !(state == S_FCS && cnt == 5'd3)) |=> gmii_tx.en);

endmodule

//--- logic/rx_cache.sv
// rx_cache: packs received bytes into words and commits or rolls back each frame
`timescale 1ns/1ps

module rx_cache
    import eth_trans_pkg::*;
(
    input  logic          sys_clk,
    input  logic          rst,
    input  rec_byte_t     rec,
    input  frame_status_t status,
    input  logic          rd_en,
    output logic [15:0]   rd_data,
    output logic          ready
);

    logic [15:0]          mem [RX_CACHE_WORDS];
    logic [RX_CACHE_AW:0] wr_ptr;                  // tentative, runs ahead during a frame
    logic [RX_CACHE_AW:0] commit_ptr;
    logic [RX_CACHE_AW:0] rd_ptr;
    logic [7:0]           hi_byte;
    logic                 half;                    // high byte of a pair is held
    logic                 ovf;                     // current frame did not fit
    logic                 has_room;
    logic                 word_wr;

    assign has_room = (wr_ptr - rd_ptr) != (RX_CACHE_AW + 1)'(RX_CACHE_WORDS);
    assign word_wr  = rec.valid && half && has_room && !ovf && !status.done;

    assign ready   = (commit_ptr != rd_ptr);
    assign rd_data = mem[rd_ptr[RX_CACHE_AW-1:0]];

    always_ff @(posedge sys_clk) begin
        if (rec.valid && !half) hi_byte <= rec.data; // first byte goes high
        if (word_wr) mem[wr_ptr[RX_CACHE_AW-1:0]] <= {hi_byte, rec.data};
    end

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            half       <= 1'b0;
            ovf        <= 1'b0;
        end else begin
            if (rd_en && ready) rd_ptr <= rd_ptr + 1'b1;
            if (status.done) begin
                half <= 1'b0;
                ovf  <= 1'b0;
                if (status.good && !ovf) commit_ptr <= wr_ptr;
                else wr_ptr <= commit_ptr;         // drop the whole frame
            end else if (rec.valid) begin
                half <= ~half;
                if (word_wr) wr_ptr <= wr_ptr + 1'b1;
                else if (half) ovf <= 1'b1;
            end
        end
    end

    // committed words can never outrun the storage
    a_commit_bound: assert property (@(posedge sys_clk) disable iff (rst)
        (commit_ptr - rd_ptr) <= (RX_CACHE_AW + 1)'(RX_CACHE_WORDS));

endmodule

//--- verilog.f
logic/eth_trans_pkg.sv
logic/byte_fifo.sv
logic/mac_tx.sv
logic/mac_rx.sv
logic/rx_cache.sv
logic/eth_trans.sv
dv/eth_trans_tb.sv
